// ==== source/axil_pkg.sv ====
package axil_pkg;

   localparam int ADDR_W = 8;
   localparam int DATA_W = 32;

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   // master to slave
   typedef struct packed {
      logic [ADDR_W-1:0]   awaddr;
      logic                awvalid;
      logic [DATA_W-1:0]   wdata;
      logic [DATA_W/8-1:0] wstrb;
      logic                wvalid;
      logic                bready;
      logic [ADDR_W-1:0]   araddr;
      logic                arvalid;
      logic                rready;
   } axil_req_t;

   // slave to master
   typedef struct packed {
      logic              awready;
      logic              wready;
      logic [1:0]        bresp;
      logic              bvalid;
      logic              arready;
      logic [DATA_W-1:0] rdata;
      logic [1:0]        rresp;
      logic              rvalid;
   } axil_rsp_t;

endpackage

// ==== source/pack_pkg.sv ====
package pack_pkg;

   localparam int FILL_BITS_W = 7;
   localparam int COUNT_W     = 5;

   // register view: word_width in bits 5:0, wrap in bit 6
   typedef struct packed {
      logic       wrap;
      logic [5:0] word_width;
   } pack_cfg_t;

   // register view: word_count 4:0, sym_count 9:5, fill_bits 16:10
   typedef struct packed {
      logic [FILL_BITS_W-1:0] fill_bits;
      logic [COUNT_W-1:0]     sym_count;
      logic [COUNT_W-1:0]     word_count;
   } pack_status_t;

   localparam logic [7:0] CFG_ADDR    = 8'h00;
   localparam logic [7:0] STATUS_ADDR = 8'h04;

   // byte symbols, continuous stream
   localparam pack_cfg_t CFG_RESET = '{
      wrap:       1'b0,
      word_width: 6'd8
   };

endpackage

// ==== source/sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  DEPTH     = 8
) (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   push_i,
   input  payload_t               data_i,
   output logic                   full_o,
   input  logic                   pop_i,
   output payload_t               data_o,
   output logic                   empty_o,
   output logic [$clog2(DEPTH):0] count_o
);

   localparam int PTR_W = $clog2(DEPTH);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             do_push;
   logic             do_pop;

   // requests against a full or empty buffer are dropped
   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;

   assign full_o  = (count == DEPTH);
   assign empty_o = (count == '0);
   assign count_o = count;
   assign data_o  = mem[rd_ptr];

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // simultaneous push and pop leaves the count alone
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wr_ptr] <= data_i;
      end
   end

endmodule

// ==== source/bit_packer.sv ====
`timescale 1ns/1ns

module bit_packer #(
   parameter int SYM_W  = 8,
   parameter int WORD_W = 32
) (
   input  logic                              clk_i,
   input  logic                              rst_n_i,
   input  pack_pkg::pack_cfg_t               cfg_i,
   input  logic [SYM_W-1:0]                  sym_i,
   input  logic                              sym_avail_i,
   output logic                              sym_pop_o,
   output logic [WORD_W-1:0]                 word_o,
   input  logic                              word_space_i,
   output logic                              word_push_o,
   output logic [pack_pkg::FILL_BITS_W-1:0]  fill_bits_o
);

   import pack_pkg::*;

   localparam int ACC_W = 2 * WORD_W;
   localparam int CNT_W = $clog2(ACC_W) + 1;

   typedef enum logic [1:0] {
      S_READ,
      S_PLACE,
      S_WRITE
   } pc_t;

   pc_t              pc;
   pc_t              pc_nxt;
   logic [ACC_W-1:0] acc;
   logic [ACC_W-1:0] acc_nxt;
   logic [CNT_W-1:0] fill;
   logic [CNT_W-1:0] fill_nxt;
   logic [SYM_W-1:0] sym_q;
   logic [SYM_W-1:0] sym_bits;
   logic [CNT_W-1:0] width;
   logic [CNT_W-1:0] fill_sum;
   logic [ACC_W-1:0] placed;

   assign width    = CNT_W'(cfg_i.word_width);
   // keep only the significant low bits
   assign sym_bits = sym_q & ~({SYM_W{1'b1}} << cfg_i.word_width);
   assign fill_sum = fill + width;
   // held bits sit at the top of acc, new ones go right below them
   assign placed   = acc | (ACC_W'(sym_bits) << (CNT_W'(ACC_W) - fill_sum));

   assign word_o      = acc[ACC_W-1 -: WORD_W];
   assign fill_bits_o = FILL_BITS_W'(fill);

   always_comb begin
      pc_nxt      = pc;
      acc_nxt     = acc;
      fill_nxt    = fill;
      sym_pop_o   = 1'b0;
      word_push_o = 1'b0;

      case (pc)
         S_READ: begin
            if (sym_avail_i) begin
               sym_pop_o = 1'b1;
               pc_nxt    = S_PLACE;
            end
         end

         S_PLACE: begin
            acc_nxt  = placed;
            fill_nxt = fill_sum;
            if (cfg_i.wrap) begin
               // word is done when another symbol would not fit
               pc_nxt = (fill_sum + width > WORD_W) ? S_WRITE : S_READ;
            end else begin
               pc_nxt = (fill_sum >= WORD_W) ? S_WRITE : S_READ;
            end
         end

         S_WRITE: begin
            if (word_space_i) begin
               word_push_o = 1'b1;
               if (cfg_i.wrap) begin
                  acc_nxt  = '0;
                  fill_nxt = '0;
               end else begin
                  // remainder moves up to the top
                  acc_nxt  = acc << WORD_W;
                  fill_nxt = fill - CNT_W'(WORD_W);
               end
               pc_nxt = S_READ;
            end
         end

         default: pc_nxt = S_READ;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         pc   <= S_READ;
         acc  <= '0;
         fill <= '0;
      end else begin
         pc   <= pc_nxt;
         acc  <= acc_nxt;
         fill <= fill_nxt;
      end
   end

   always_ff @(posedge clk_i) begin
      if (sym_pop_o) begin
         sym_q <= sym_i;
      end
   end

endmodule

// ==== source/pack_csr_axil.sv ====
`timescale 1ns/1ns

module pack_csr_axil (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  axil_pkg::axil_req_t   axil_req_i,
   output axil_pkg::axil_rsp_t   axil_rsp_o,
   input  pack_pkg::pack_status_t status_i,
   output pack_pkg::pack_cfg_t   cfg_o
);

   import axil_pkg::*;
   import pack_pkg::*;

   pack_cfg_t         cfg_q;
   logic              wr_fire;
   logic              rd_fire;
   logic              bvalid_q;
   logic              rvalid_q;
   logic [1:0]        bresp_q;
   logic [1:0]        rresp_q;
   logic [DATA_W-1:0] rdata_q;

   // AW and W are taken together, one write outstanding
   assign wr_fire = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q;
   assign rd_fire = axil_req_i.arvalid && !rvalid_q;

   always_comb begin
      axil_rsp_o.awready = wr_fire;
      axil_rsp_o.wready  = wr_fire;
      axil_rsp_o.bresp   = bresp_q;
      axil_rsp_o.bvalid  = bvalid_q;
      axil_rsp_o.arready = rd_fire;
      axil_rsp_o.rdata   = rdata_q;
      axil_rsp_o.rresp   = rresp_q;
      axil_rsp_o.rvalid  = rvalid_q;
   end

   assign cfg_o = cfg_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         cfg_q    <= CFG_RESET;
         bvalid_q <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         if (wr_fire) begin
            bvalid_q <= 1'b1;
            if (axil_req_i.awaddr == CFG_ADDR && axil_req_i.wstrb[0]) begin
               cfg_q <= pack_cfg_t'(axil_req_i.wdata[$bits(pack_cfg_t)-1:0]);
            end
         end else if (bvalid_q && axil_req_i.bready) begin
            bvalid_q <= 1'b0;
         end

         if (rd_fire) begin
            rvalid_q <= 1'b1;
         end else if (rvalid_q && axil_req_i.rready) begin
            rvalid_q <= 1'b0;
         end
      end
   end

   // response payload
   always_ff @(posedge clk_i) begin
      if (wr_fire) begin
         // status is read only, writes there are dropped quietly
         if (axil_req_i.awaddr == CFG_ADDR || axil_req_i.awaddr == STATUS_ADDR) begin
            bresp_q <= RESP_OKAY;
         end else begin
            bresp_q <= RESP_SLVERR;
         end
      end
      if (rd_fire) begin
         case (axil_req_i.araddr)
            CFG_ADDR: begin
               rdata_q <= DATA_W'(cfg_q);
               rresp_q <= RESP_OKAY;
            end
            STATUS_ADDR: begin
               rdata_q <= DATA_W'(status_i);
               rresp_q <= RESP_OKAY;
            end
            default: begin
               rdata_q <= '0;
               rresp_q <= RESP_SLVERR;
            end
         endcase
      end
   end

endmodule

// ==== source/bit_pack_top.sv ====
`timescale 1ns/1ns

module bit_pack_top #(
   parameter int SYM_W      = 8,
   parameter int WORD_W     = 32,
   parameter int FIFO_DEPTH = 8
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  axil_pkg::axil_req_t axil_req_i,
   output axil_pkg::axil_rsp_t axil_rsp_o,
   input  logic [SYM_W-1:0]    sym_i,
   input  logic                sym_valid_i,
   output logic                sym_ready_o,
   output logic [WORD_W-1:0]   word_o,
   output logic                word_valid_o,
   input  logic                word_ready_i
);

   import pack_pkg::*;

   localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

   typedef logic [SYM_W-1:0]  sym_t;
   typedef logic [WORD_W-1:0] word_t;

   pack_cfg_t              cfg;
   pack_status_t           status;
   sym_t                   sym_data;
   logic                   sym_full;
   logic                   sym_empty;
   logic                   sym_pop;
   logic [CNT_W-1:0]       sym_cnt;
   word_t                  word_data;
   logic                   word_full;
   logic                   word_empty;
   logic                   word_push;
   logic [CNT_W-1:0]       word_cnt;
   logic [FILL_BITS_W-1:0] fill_bits;

   assign sym_ready_o  = !sym_full;
   assign word_valid_o = !word_empty;

   assign status.fill_bits  = fill_bits;
   assign status.sym_count  = COUNT_W'(sym_cnt);
   assign status.word_count = COUNT_W'(word_cnt);

   pack_csr_axil u_csr (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .axil_req_i (axil_req_i),
      .axil_rsp_o (axil_rsp_o),
      .status_i   (status),
      .cfg_o      (cfg)
   );

   // input side, symbols
   sync_fifo #(
      .payload_t (sym_t),
      .DEPTH     (FIFO_DEPTH)
   ) u_sym_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (sym_valid_i),
      .data_i  (sym_i),
      .full_o  (sym_full),
      .pop_i   (sym_pop),
      .data_o  (sym_data),
      .empty_o (sym_empty),
      .count_o (sym_cnt)
   );

   bit_packer #(
      .SYM_W  (SYM_W),
      .WORD_W (WORD_W)
   ) u_packer (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .cfg_i        (cfg),
      .sym_i        (sym_data),
      .sym_avail_i  (!sym_empty),
      .sym_pop_o    (sym_pop),
      .word_o       (word_data),
      .word_space_i (!word_full),
      .word_push_o  (word_push),
      .fill_bits_o  (fill_bits)
   );

   // output side, packed words
   sync_fifo #(
      .payload_t (word_t),
      .DEPTH     (FIFO_DEPTH)
   ) u_word_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (word_push),
      .data_i  (word_data),
      .full_o  (word_full),
      .pop_i   (word_ready_i),
      .data_o  (word_o),
      .empty_o (word_empty),
      .count_o (word_cnt)
   );

endmodule

// ==== tb/tb_bit_pack.sv ====
`timescale 1ns/1ns

module tb_bit_pack;

   import axil_pkg::*;
   import pack_pkg::*;

   // longest test is about 40 symbols at a few cycles each, plus CSR traffic
   localparam int MAX_CYCLES = 5000;
   localparam int FIFO_DEPTH = 8;
   // full word FIFO, one finished word held in the packer, full symbol FIFO
   localparam int STALL_SYMS = FIFO_DEPTH * 4 + 4 + FIFO_DEPTH;

   logic        clk_i;
   logic        rst_n_i;
   axil_req_t   req;
   axil_rsp_t   rsp;
   logic [7:0]  sym_i;
   logic        sym_valid_i;
   logic        sym_ready_o;
   logic [31:0] word_o;
   logic        word_valid_o;
   logic        word_ready_i;

   int          errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          cycles = 0;
   int          e0;
   logic [31:0] lcg_state = 32'd31932;
   logic [7:0]  sym_list[$];
   logic [31:0] exp_words[$];

   bit_pack_top dut (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .axil_req_i   (req),
      .axil_rsp_o   (rsp),
      .sym_i        (sym_i),
      .sym_valid_i  (sym_valid_i),
      .sym_ready_o  (sym_ready_o),
      .word_o       (word_o),
      .word_valid_o (word_valid_o),
      .word_ready_i (word_ready_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles == MAX_CYCLES) begin
         $display("timeout: run stopped after %0d cycles", MAX_CYCLES);
         $display(">>> FAIL");
         $finish;
      end
   end

   function automatic logic [7:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[23:16];
   endfunction

   // expected words from the sent symbols, continuous or wrapped
   function automatic void build_expected(input int width, input bit wrap);
      logic [31:0] cur;
      logic [7:0]  bits;
      int          nbits;
      int          slot;
      cur   = '0;
      nbits = 0;
      slot  = 0;
      exp_words.delete();
      foreach (sym_list[i]) begin
         bits = sym_list[i] & (8'hff >> (8 - width));
         if (wrap) begin
            cur  = cur | (32'(bits) << (32 - (slot + 1) * width));
            slot = slot + 1;
            if (slot == 32 / width) begin
               exp_words.push_back(cur);
               cur  = '0;
               slot = 0;
            end
         end else begin
            for (int b = width - 1; b >= 0; b--) begin
               cur   = {cur[30:0], bits[b]};
               nbits = nbits + 1;
               if (nbits == 32) begin
                  exp_words.push_back(cur);
                  nbits = 0;
               end
            end
         end
      end
   endfunction

   task automatic check_eq(input logic [31:0] exp, input logic [31:0] act, input string msg);
      if (exp !== act) begin
         errors++;
         $display("Fail at %0t ns: %s, expected %h, got %h", $time, msg, exp, act);
      end
   endtask

   task automatic next_cycle();
      @(posedge clk_i);
      #2;
   endtask

   task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
      req.awaddr  = addr;
      req.awvalid = 1'b1;
      req.wdata   = data;
      req.wstrb   = 4'hf;
      req.wvalid  = 1'b1;
      // awready follows the valids combinationally, let it settle
      #1;
      while (!rsp.awready) begin
         @(posedge clk_i);
         #3;
      end
      next_cycle();
      req.awvalid = 1'b0;
      req.wvalid  = 1'b0;
      while (!rsp.bvalid) next_cycle();
      resp       = rsp.bresp;
      req.bready = 1'b1;
      next_cycle();
      req.bready = 1'b0;
   endtask

   task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
      req.araddr  = addr;
      req.arvalid = 1'b1;
      #1;
      while (!rsp.arready) begin
         @(posedge clk_i);
         #3;
      end
      next_cycle();
      req.arvalid = 1'b0;
      while (!rsp.rvalid) next_cycle();
      data       = rsp.rdata;
      resp       = rsp.rresp;
      req.rready = 1'b1;
      next_cycle();
      req.rready = 1'b0;
   endtask

   task automatic send_sym(input logic [7:0] s);
      sym_i       = s;
      sym_valid_i = 1'b1;
      while (!sym_ready_o) next_cycle();
      next_cycle();
      sym_valid_i = 1'b0;
   endtask

   task automatic get_word(output logic [31:0] w, input int hold);
      word_ready_i = 1'b0;
      repeat (hold) next_cycle();
      while (!word_valid_o) next_cycle();
      w            = word_o;
      word_ready_i = 1'b1;
      next_cycle();
      word_ready_i = 1'b0;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == e0) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: failed", name);
      end
   endtask

   task automatic test_reset_state();
      logic [31:0] d;
      logic [1:0]  resp;
      check_eq(0, word_valid_o, "word_valid_o after reset");
      check_eq(1, sym_ready_o, "sym_ready_o after reset");
      axil_read(CFG_ADDR, d, resp);
      check_eq(32'h08, d, "reset config");
      axil_read(STATUS_ADDR, d, resp);
      check_eq(0, d, "reset status");
   endtask

   task automatic test_registers();
      logic [31:0] d;
      logic [1:0]  resp;
      axil_write(CFG_ADDR, 32'h45, resp);
      check_eq(RESP_OKAY, resp, "config write response");
      axil_read(CFG_ADDR, d, resp);
      check_eq(32'h45, d, "config readback");
      check_eq(RESP_OKAY, resp, "config read response");
      axil_write(STATUS_ADDR, 32'h1234, resp);
      check_eq(RESP_OKAY, resp, "status write response");
      axil_read(8'h08, d, resp);
      check_eq(RESP_SLVERR, resp, "unmapped read response");
   endtask

   // configure, send LCG symbols, then drain and compare against the model
   task automatic run_stream(input int width, input bit wrap, input int nsyms);
      logic [31:0] w;
      logic [7:0]  s;
      logic [1:0]  resp;
      int          rem;
      rem = 32 - (32 / width) * width;
      axil_write(CFG_ADDR, {25'd0, wrap, 6'(width)}, resp);
      sym_list.delete();
      for (int i = 0; i < nsyms; i++) begin
         s = lcg_next();
         sym_list.push_back(s);
         send_sym(s);
      end
      build_expected(width, wrap);
      foreach (exp_words[i]) begin
         get_word(w, 0);
         check_eq(exp_words[i], w, $sformatf("word %0d", i));
         if (wrap && rem > 0) begin
            check_eq(0, w << (32 - rem), $sformatf("unused low bits of word %0d", i));
         end
      end
      repeat (10) next_cycle();
      check_eq(0, word_valid_o, "no extra word");
   endtask

   task automatic test_backpressure();
      logic [31:0] w;
      logic [31:0] st;
      logic [7:0]  s;
      logic [1:0]  resp;
      axil_write(CFG_ADDR, 32'h08, resp);
      sym_list.delete();
      // keep sending through short stalls until the whole path is full
      for (int i = 0; i < STALL_SYMS; i++) begin
         s = lcg_next();
         sym_list.push_back(s);
         send_sym(s);
      end
      check_eq(0, sym_ready_o, "sym_ready_o under back-pressure");
      axil_read(STATUS_ADDR, st, resp);
      check_eq(FIFO_DEPTH, st[4:0], "word FIFO count");
      check_eq(FIFO_DEPTH, st[9:5], "symbol FIFO count");
      build_expected(8, 1'b0);
      foreach (exp_words[i]) begin
         get_word(w, 2);
         check_eq(exp_words[i], w, $sformatf("released word %0d", i));
      end
   endtask

   initial begin
      rst_n_i      = 1'b0;
      req          = '0;
      sym_i        = '0;
      sym_valid_i  = 1'b0;
      word_ready_i = 1'b0;
      repeat (8) @(posedge clk_i);
      #2;
      rst_n_i = 1'b1;
      next_cycle();

      e0 = errors;
      test_reset_state();
      end_test("reset state");
      e0 = errors;
      test_registers();
      end_test("register access");
      e0 = errors;
      run_stream(8, 1'b0, 8);
      end_test("byte packing");
      e0 = errors;
      run_stream(5, 1'b0, 32);
      end_test("continuous width 5");
      e0 = errors;
      run_stream(5, 1'b1, 12);
      end_test("wrap width 5");
      e0 = errors;
      test_backpressure();
      end_test("back-pressure");

      $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// ==== filelist.f ====
source/axil_pkg.sv
source/pack_pkg.sv
source/sync_fifo.sv
source/bit_packer.sv
source/pack_csr_axil.sv
source/bit_pack_top.sv
tb/tb_bit_pack.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the bit packer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
   --top-module tb_bit_pack \
   -f filelist.f \
   -Mdir obj_dir \
   -o sim_bit_pack > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "build failed, see build.log"
   exit 1
fi

./obj_dir/sim_bit_pack > sim.log 2>&1
if [ $? -ne 0 ]; then
   cat sim.log
   echo "simulation exited with an error, see sim.log"
   exit 1
fi

cat sim.log

if grep -q "^>>> PASS$" sim.log; then
   exit 0
else
   exit 1
fi
